// File: source/qs_srt_pkg.sv
/*
  Machine types and microcode encoding for the quicksort engine.
  Keys are unsigned. Keys, indices and stack entries share one 16-bit word.
  Immediates are 3 bits, which covers the 0 and 1 that the microcode needs.
*/
package qs_srt_pkg;

  // Key, array index and stack entry
  typedef logic [15:0] word_t;

  // Microcode address
  typedef logic [7:0] pc_t;

  // Major opcodes
  typedef enum logic [3:0] {
    NOP   = 4'b0000,
    JCC   = 4'b0001,
    STK   = 4'b0010,
    MEM   = 4'b0100,
    MOV   = 4'b0110,
    ARITH = 4'b0111,
    CALL  = 4'b1100,
    CTRL  = 4'b1111
  } opcode_t;

  // Jump conditions, AL is unconditional
  typedef enum logic [1:0] {AL, EQ, GT, LE} cc_t;

  // BLINK holds the return address
  typedef enum logic [2:0] {R0, R1, R2, R3, R4, R5, R6, BLINK} reg_t;

  // Special registers readable by MOVS
  typedef enum logic [2:0] {REG_N = 3'd0} sreg_t;

  // JCC and CALL reuse the low byte as the target address
  typedef struct packed {
    opcode_t    op;
    logic       sub;
    reg_t       dst;
    logic       wf;
    reg_t       src;
    logic       imm;
    logic [2:0] opb;
  } inst_t;

  // Error self-loop
  localparam pc_t SYM_ERR = 8'd128;

  function automatic inst_t enc(opcode_t op, logic sub, reg_t dst, logic wf,
                                reg_t src, logic imm, logic [2:0] opb);
    return '{op, sub, dst, wf, src, imm, opb};
  endfunction

  function automatic inst_t j(pc_t tgt, cc_t cc = AL);
    return enc(JCC, 1'b0, reg_t'({1'b0, cc}), tgt[7], reg_t'(tgt[6:4]), tgt[3], tgt[2:0]);
  endfunction

  function automatic inst_t push(reg_t r);
    return enc(STK, 1'b0, R0, 1'b0, R0, 1'b0, r);
  endfunction

  function automatic inst_t pop(reg_t r);
    return enc(STK, 1'b1, r, 1'b0, R0, 1'b0, 3'd0);
  endfunction

  // Address register sits in opb for both LD and ST
  function automatic inst_t ld(reg_t d, reg_t a);
    return enc(MEM, 1'b0, d, 1'b0, R0, 1'b0, a);
  endfunction

  function automatic inst_t st(reg_t a, reg_t s);
    return enc(MEM, 1'b1, R0, 1'b0, s, 1'b0, a);
  endfunction

  function automatic inst_t mov(reg_t d, reg_t s);
    return enc(MOV, 1'b0, d, 1'b0, R0, 1'b0, s);
  endfunction

  function automatic inst_t movi(reg_t d, logic [2:0] v);
    return enc(MOV, 1'b0, d, 1'b0, R0, 1'b1, v);
  endfunction

  function automatic inst_t movs(reg_t d, sreg_t s);
    return enc(MOV, 1'b1, d, 1'b0, R0, 1'b0, s);
  endfunction

  function automatic inst_t addi(reg_t d, reg_t s, logic [2:0] v);
    return enc(ARITH, 1'b0, d, 1'b0, s, 1'b1, v);
  endfunction

  function automatic inst_t subi(reg_t d, reg_t s, logic [2:0] v);
    return enc(ARITH, 1'b1, d, 1'b0, s, 1'b1, v);
  endfunction

  // Flags only, the difference is dropped
  function automatic inst_t cmp(reg_t a, reg_t b);
    return enc(ARITH, 1'b1, R0, 1'b1, a, 1'b0, b);
  endfunction

  function automatic inst_t call(pc_t tgt);
    return enc(CALL, 1'b0, R0, tgt[7], reg_t'(tgt[6:4]), tgt[3], tgt[2:0]);
  endfunction

  function automatic inst_t ret();
    return enc(CALL, 1'b1, R0, 1'b0, R0, 1'b0, 3'd0);
  endfunction

  function automatic inst_t await();
    return enc(CTRL, 1'b0, R0, 1'b0, R0, 1'b0, 3'd0);
  endfunction

  function automatic inst_t emit();
    return enc(CTRL, 1'b1, R0, 1'b0, R0, 1'b0, 3'd0);
  endfunction

endpackage

// File: source/qs_srt_ucode_rom.sv
/*
  Control store for the quicksort engine, one 32-entry region per routine.
  Every address not listed decodes to a jump into the error self-loop.
*/
`timescale 1ns/1ns

module qs_srt_ucode_rom (
  input  qs_srt_pkg::pc_t   ra,
  output qs_srt_pkg::inst_t rout
);

  // Routine entry points
  localparam qs_srt_pkg::pc_t SYM_RESET = 8'd0;
  localparam qs_srt_pkg::pc_t SYM_PART  = 8'd32;
  localparam qs_srt_pkg::pc_t SYM_QS    = 8'd64;
  localparam qs_srt_pkg::pc_t SYM_START = 8'd96;

  // Branch targets inside the routines
  localparam qs_srt_pkg::pc_t SYM_PART_LOOP = SYM_PART + 8'd8;
  localparam qs_srt_pkg::pc_t SYM_PART_NEXT = SYM_PART + 8'd17;
  localparam qs_srt_pkg::pc_t SYM_PART_END  = SYM_PART + 8'd19;
  localparam qs_srt_pkg::pc_t SYM_QS_END    = SYM_QS + 8'd18;
  localparam qs_srt_pkg::pc_t SYM_WAIT      = SYM_START + 8'd8;

  // R0 = lo, R1 = hi on entry to both routines
  // Partition returns the pivot index in R0 and clobbers R1
  always_comb begin
    rout = qs_srt_pkg::j(qs_srt_pkg::SYM_ERR);
    case (ra[7:5])
      // Reset vector
      3'd0: begin
        if (ra == SYM_RESET) rout = qs_srt_pkg::j(SYM_START);
      end
      // Lomuto partition, pivot is A[hi]
      3'd1: begin
        case (ra[4:0])
          5'd0:  rout = qs_srt_pkg::push(qs_srt_pkg::R2);
          5'd1:  rout = qs_srt_pkg::push(qs_srt_pkg::R3);
          5'd2:  rout = qs_srt_pkg::push(qs_srt_pkg::R4);
          5'd3:  rout = qs_srt_pkg::push(qs_srt_pkg::R5);
          5'd4:  rout = qs_srt_pkg::push(qs_srt_pkg::R6);
          5'd5:  rout = qs_srt_pkg::ld(qs_srt_pkg::R2, qs_srt_pkg::R1);
          5'd6:  rout = qs_srt_pkg::mov(qs_srt_pkg::R3, qs_srt_pkg::R0);
          5'd7:  rout = qs_srt_pkg::mov(qs_srt_pkg::R4, qs_srt_pkg::R0);
          // Loop head, stop when j reaches hi
          5'd8:  rout = qs_srt_pkg::cmp(qs_srt_pkg::R1, qs_srt_pkg::R4);
          5'd9:  rout = qs_srt_pkg::j(SYM_PART_END, qs_srt_pkg::EQ);
          5'd10: rout = qs_srt_pkg::ld(qs_srt_pkg::R5, qs_srt_pkg::R4);
          // Keys above the pivot stay where they are
          5'd11: rout = qs_srt_pkg::cmp(qs_srt_pkg::R5, qs_srt_pkg::R2);
          5'd12: rout = qs_srt_pkg::j(SYM_PART_NEXT, qs_srt_pkg::GT);
          // Swap A[i] and A[j], then i++
          5'd13: rout = qs_srt_pkg::ld(qs_srt_pkg::R6, qs_srt_pkg::R3);
          5'd14: rout = qs_srt_pkg::st(qs_srt_pkg::R3, qs_srt_pkg::R5);
          5'd15: rout = qs_srt_pkg::st(qs_srt_pkg::R4, qs_srt_pkg::R6);
          5'd16: rout = qs_srt_pkg::addi(qs_srt_pkg::R3, qs_srt_pkg::R3, 3'd1);
          5'd17: rout = qs_srt_pkg::addi(qs_srt_pkg::R4, qs_srt_pkg::R4, 3'd1);
          5'd18: rout = qs_srt_pkg::j(SYM_PART_LOOP);
          // Move pivot into A[i], here R4 equals hi
          5'd19: rout = qs_srt_pkg::ld(qs_srt_pkg::R0, qs_srt_pkg::R3);
          5'd20: rout = qs_srt_pkg::ld(qs_srt_pkg::R1, qs_srt_pkg::R4);
          5'd21: rout = qs_srt_pkg::st(qs_srt_pkg::R3, qs_srt_pkg::R1);
          5'd22: rout = qs_srt_pkg::st(qs_srt_pkg::R4, qs_srt_pkg::R0);
          5'd23: rout = qs_srt_pkg::mov(qs_srt_pkg::R0, qs_srt_pkg::R3);
          5'd24: rout = qs_srt_pkg::pop(qs_srt_pkg::R6);
          5'd25: rout = qs_srt_pkg::pop(qs_srt_pkg::R5);
          5'd26: rout = qs_srt_pkg::pop(qs_srt_pkg::R4);
          5'd27: rout = qs_srt_pkg::pop(qs_srt_pkg::R3);
          5'd28: rout = qs_srt_pkg::pop(qs_srt_pkg::R2);
          5'd29: rout = qs_srt_pkg::ret();
          default: ;
        endcase
      end
      // Recursive quicksort
      3'd2: begin
        case (ra[4:0])
          5'd0:  rout = qs_srt_pkg::push(qs_srt_pkg::BLINK);
          5'd1:  rout = qs_srt_pkg::push(qs_srt_pkg::R2);
          5'd2:  rout = qs_srt_pkg::push(qs_srt_pkg::R3);
          5'd3:  rout = qs_srt_pkg::push(qs_srt_pkg::R4);
          // hi may be lo-1 = 0xFFFF, so compare hi+1 with lo+1
          5'd4:  rout = qs_srt_pkg::addi(qs_srt_pkg::R2, qs_srt_pkg::R0, 3'd1);
          5'd5:  rout = qs_srt_pkg::addi(qs_srt_pkg::R3, qs_srt_pkg::R1, 3'd1);
          5'd6:  rout = qs_srt_pkg::cmp(qs_srt_pkg::R3, qs_srt_pkg::R2);
          5'd7:  rout = qs_srt_pkg::mov(qs_srt_pkg::R2, qs_srt_pkg::R0);
          5'd8:  rout = qs_srt_pkg::mov(qs_srt_pkg::R4, qs_srt_pkg::R1);
          // MOV leaves the flags alone
          5'd9:  rout = qs_srt_pkg::j(SYM_QS_END, qs_srt_pkg::LE);
          5'd10: rout = qs_srt_pkg::call(SYM_PART);
          5'd11: rout = qs_srt_pkg::mov(qs_srt_pkg::R3, qs_srt_pkg::R0);
          // Left half [lo, p-1]
          5'd12: rout = qs_srt_pkg::mov(qs_srt_pkg::R0, qs_srt_pkg::R2);
          5'd13: rout = qs_srt_pkg::subi(qs_srt_pkg::R1, qs_srt_pkg::R3, 3'd1);
          5'd14: rout = qs_srt_pkg::call(SYM_QS);
          // Right half [p+1, hi]
          5'd15: rout = qs_srt_pkg::addi(qs_srt_pkg::R0, qs_srt_pkg::R3, 3'd1);
          5'd16: rout = qs_srt_pkg::mov(qs_srt_pkg::R1, qs_srt_pkg::R4);
          5'd17: rout = qs_srt_pkg::call(SYM_QS);
          5'd18: rout = qs_srt_pkg::pop(qs_srt_pkg::R4);
          5'd19: rout = qs_srt_pkg::pop(qs_srt_pkg::R3);
          5'd20: rout = qs_srt_pkg::pop(qs_srt_pkg::R2);
          5'd21: rout = qs_srt_pkg::pop(qs_srt_pkg::BLINK);
          5'd22: rout = qs_srt_pkg::ret();
          default: ;
        endcase
      end
      // Entry point, clear state then serve banks forever
      3'd3: begin
        case (ra[4:0])
          5'd0:  rout = qs_srt_pkg::movi(qs_srt_pkg::R0, 3'd0);
          5'd1:  rout = qs_srt_pkg::movi(qs_srt_pkg::R1, 3'd0);
          5'd2:  rout = qs_srt_pkg::movi(qs_srt_pkg::R2, 3'd0);
          5'd3:  rout = qs_srt_pkg::movi(qs_srt_pkg::R3, 3'd0);
          5'd4:  rout = qs_srt_pkg::movi(qs_srt_pkg::R4, 3'd0);
          5'd5:  rout = qs_srt_pkg::movi(qs_srt_pkg::R5, 3'd0);
          5'd6:  rout = qs_srt_pkg::movi(qs_srt_pkg::R6, 3'd0);
          5'd7:  rout = qs_srt_pkg::movi(qs_srt_pkg::BLINK, 3'd0);
          // Stall here until the bank is full
          5'd8:  rout = qs_srt_pkg::await();
          5'd9:  rout = qs_srt_pkg::movi(qs_srt_pkg::R0, 3'd0);
          5'd10: rout = qs_srt_pkg::movs(qs_srt_pkg::R1, qs_srt_pkg::REG_N);
          5'd11: rout = qs_srt_pkg::call(SYM_QS);
          5'd12: rout = qs_srt_pkg::emit();
          5'd13: rout = qs_srt_pkg::j(SYM_WAIT);
          default: ;
        endcase
      end
      default: ;
    endcase
  end

endmodule

// File: source/qs_srt_seq.sv
/*
  Microsequencer, one instruction per cycle.
  Return addresses come back from the datapath through BLINK, low byte only.
*/
`timescale 1ns/1ns

module qs_srt_seq (
  input  logic                clk,
  input  logic                rst,
  input  qs_srt_pkg::inst_t   inst,
  input  logic                flag_z,
  input  logic                flag_gt,
  input  qs_srt_pkg::word_t   blink,
  input  logic                full,
  output qs_srt_pkg::pc_t     pc,
  output logic                link_wr,
  output qs_srt_pkg::pc_t     link_pc,
  output logic                stall,
  output logic                emit
);

  qs_srt_pkg::pc_t pc_inc;
  qs_srt_pkg::pc_t pc_nxt;
  logic            taken;

  assign pc_inc  = pc + 8'd1;
  assign link_pc = pc_inc;

  // Condition code sits in the low two bits of the dst field
  always_comb begin
    case (qs_srt_pkg::cc_t'(inst[9:8]))
      qs_srt_pkg::EQ: taken = flag_z;
      qs_srt_pkg::GT: taken = flag_gt;
      qs_srt_pkg::LE: taken = !flag_gt;
      default:        taken = 1'b1;
    endcase
  end

  always_comb begin
    pc_nxt  = pc_inc;
    link_wr = 1'b0;
    stall   = 1'b0;
    emit    = 1'b0;
    case (inst.op)
      qs_srt_pkg::JCC: begin
        if (taken) pc_nxt = inst[7:0];
      end
      qs_srt_pkg::CALL: begin
        if (inst.sub) begin
          // RET
          pc_nxt = blink[7:0];
        end else begin
          pc_nxt  = inst[7:0];
          link_wr = 1'b1;
        end
      end
      qs_srt_pkg::CTRL: begin
        if (inst.sub) begin
          emit = 1'b1;
        end else if (!full) begin
          // AWAIT holds until the bank is loaded
          stall  = 1'b1;
          pc_nxt = pc;
        end
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) pc <= '0;
    else pc <= pc_nxt;
  end

  // Reaching the error loop means a bad jump or a corrupted return address
  a_no_err: assert property (@(posedge clk) disable iff (rst) pc != qs_srt_pkg::SYM_ERR);

endmodule

// File: source/qs_srt_datapath.sv
/*
  Register file, adder/subtractor, call stack and array access.
  Flags only change on a flag-writing SUB, compared unsigned.
  STACK_N must cover the recursion, roughly 5*N+8 entries.
*/
`timescale 1ns/1ns

module qs_srt_datapath #(
  parameter int N       = 8,
  parameter int STACK_N = 48
) (
  input  logic                clk,
  input  logic                rst,
  input  qs_srt_pkg::inst_t   inst,
  input  logic                stall,
  input  logic                link_wr,
  input  qs_srt_pkg::pc_t     link_pc,
  input  qs_srt_pkg::word_t   mem_rdata,
  output logic                flag_z,
  output logic                flag_gt,
  output qs_srt_pkg::word_t   blink,
  output qs_srt_pkg::word_t   mem_addr,
  output logic                mem_wr,
  output qs_srt_pkg::word_t   mem_wdata
);

  localparam int SPW = $clog2(STACK_N + 1);

  qs_srt_pkg::word_t regs [8];
  qs_srt_pkg::word_t stack [STACK_N];
  logic [SPW-1:0]    sp;

  qs_srt_pkg::word_t opa;
  qs_srt_pkg::word_t opb;
  qs_srt_pkg::word_t res;
  qs_srt_pkg::word_t sval;
  logic              do_push;
  logic              do_pop;
  logic              do_mem;
  logic              do_cmp;

  // Operand A from src, operand B from opb as register or immediate
  assign opa = regs[inst.src];
  assign opb = inst.imm ? qs_srt_pkg::word_t'(inst.opb) : regs[inst.opb];
  assign res = inst.sub ? opa - opb : opa + opb;

  // Special register read for MOVS
  always_comb begin
    case (qs_srt_pkg::sreg_t'(inst.opb))
      qs_srt_pkg::REG_N: sval = qs_srt_pkg::word_t'(N - 1);
      default:           sval = '0;
    endcase
  end

  assign do_push = !stall && inst.op == qs_srt_pkg::STK && !inst.sub;
  assign do_pop  = !stall && inst.op == qs_srt_pkg::STK && inst.sub;
  assign do_mem  = !stall && inst.op == qs_srt_pkg::MEM;
  assign do_cmp  = !stall && inst.op == qs_srt_pkg::ARITH && inst.sub && inst.wf;

  // Array port, address always from the opb register
  assign mem_addr  = regs[inst.opb];
  assign mem_wdata = opa;
  assign mem_wr    = do_mem && inst.sub;

  assign blink = regs[qs_srt_pkg::BLINK];

  // Register writes, the start routine clears them
  always_ff @(posedge clk) begin
    if (link_wr) begin
      regs[qs_srt_pkg::BLINK] <= qs_srt_pkg::word_t'(link_pc);
    end else if (!stall) begin
      case (inst.op)
        qs_srt_pkg::MOV:   regs[inst.dst] <= inst.sub ? sval : opb;
        qs_srt_pkg::ARITH: begin
          if (!inst.wf) regs[inst.dst] <= res;
        end
        qs_srt_pkg::MEM: begin
          if (!inst.sub) regs[inst.dst] <= mem_rdata;
        end
        qs_srt_pkg::STK: begin
          if (inst.sub) regs[inst.dst] <= stack[sp - 1'b1];
        end
        default: ;
      endcase
    end
  end

  // Stack storage
  always_ff @(posedge clk) begin
    if (do_push) stack[sp] <= regs[inst.opb];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      sp      <= '0;
      flag_z  <= 1'b0;
      flag_gt <= 1'b0;
    end else begin
      if (do_push) sp <= sp + 1'b1;
      else if (do_pop) sp <= sp - 1'b1;
      if (do_cmp) begin
        flag_z  <= opa == opb;
        flag_gt <= opa > opb;
      end
    end
  end

  // Recursion deeper than the stack corrupts return addresses
  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    do_push |-> sp < SPW'(STACK_N));
  a_no_underflow: assert property (@(posedge clk) disable iff (rst)
    do_pop |-> sp != '0);

  // Partition must only touch indices inside the bank
  a_addr_range: assert property (@(posedge clk) disable iff (rst)
    do_mem |-> mem_addr < qs_srt_pkg::word_t'(N));

endmodule

// File: source/qs_srt_array.sv
/*
  Single key bank with host fill, engine access and in-order drain.
  Host keys are dropped while busy. The drain has no back-pressure.
  mem_rdata is combinational so LD completes in one cycle.
*/
`timescale 1ns/1ns

module qs_srt_array #(
  parameter int N = 8
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_vld,
  input  qs_srt_pkg::word_t   in_key,
  input  qs_srt_pkg::word_t   mem_addr,
  input  logic                mem_wr,
  input  qs_srt_pkg::word_t   mem_wdata,
  input  logic                emit,
  output qs_srt_pkg::word_t   mem_rdata,
  output logic                full,
  output logic                busy,
  output logic                out_vld,
  output qs_srt_pkg::word_t   out_key
);

  localparam int AW = (N > 1) ? $clog2(N) : 1;

  qs_srt_pkg::word_t mem [N];
  logic [AW-1:0]     fill_cnt;
  logic [AW-1:0]     drn_cnt;
  logic [AW-1:0]     addr;
  logic              draining;
  logic              load;

  assign load      = in_vld && !busy;
  assign addr      = mem_addr[AW-1:0];
  assign mem_rdata = mem[addr];

  // Drain reads straight from the bank
  assign out_vld = draining;
  assign out_key = mem[drn_cnt];

  // Host and engine never write in the same cycle
  always_ff @(posedge clk) begin
    if (load) mem[fill_cnt] <= in_key;
    else if (mem_wr) mem[addr] <= mem_wdata;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      fill_cnt <= '0;
      drn_cnt  <= '0;
      full     <= 1'b0;
      busy     <= 1'b0;
      draining <= 1'b0;
    end else begin
      if (load) begin
        if (fill_cnt == AW'(N - 1)) begin
          fill_cnt <= '0;
          full     <= 1'b1;
          busy     <= 1'b1;
        end else begin
          fill_cnt <= fill_cnt + 1'b1;
        end
      end
      // Sort done, hand the bank to the drain
      if (emit) begin
        full     <= 1'b0;
        draining <= 1'b1;
      end
      if (draining) begin
        if (drn_cnt == AW'(N - 1)) begin
          drn_cnt  <= '0;
          draining <= 1'b0;
          busy     <= 1'b0;
        end else begin
          drn_cnt <= drn_cnt + 1'b1;
        end
      end
    end
  end

  a_wr_full: assert property (@(posedge clk) disable iff (rst) mem_wr |-> full);
  a_emit_full: assert property (@(posedge clk) disable iff (rst) emit |-> full);

endmodule

// File: source/qs_srt.sv
/*
  Microcoded quicksort engine for one bank of N unsigned keys.
  Host loads N keys by strobe, then takes N sorted keys on consecutive cycles.
  STACK_N defaults to 5*N+8, enough for the worst-case recursion.
*/
`timescale 1ns/1ns

module qs_srt #(
  parameter int N       = 8,
  parameter int STACK_N = 5 * N + 8
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_vld,
  input  qs_srt_pkg::word_t   in_key,
  output logic                out_vld,
  output qs_srt_pkg::word_t   out_key,
  output logic                busy
);

  qs_srt_pkg::inst_t inst;
  qs_srt_pkg::pc_t   pc;
  qs_srt_pkg::pc_t   link_pc;
  qs_srt_pkg::word_t blink;
  qs_srt_pkg::word_t mem_addr;
  qs_srt_pkg::word_t mem_wdata;
  qs_srt_pkg::word_t mem_rdata;
  logic              flag_z;
  logic              flag_gt;
  logic              link_wr;
  logic              stall;
  logic              emit;
  logic              full;
  logic              mem_wr;

  qs_srt_ucode_rom rom_i (.ra(pc), .rout(inst));

  qs_srt_seq seq_i (
    .clk(clk), .rst(rst), .inst(inst), .flag_z(flag_z), .flag_gt(flag_gt),
    .blink(blink), .full(full), .pc(pc), .link_wr(link_wr), .link_pc(link_pc),
    .stall(stall), .emit(emit)
  );

  qs_srt_datapath #(.N(N), .STACK_N(STACK_N)) datapath_i (
    .clk(clk), .rst(rst), .inst(inst), .stall(stall), .link_wr(link_wr),
    .link_pc(link_pc), .mem_rdata(mem_rdata), .flag_z(flag_z), .flag_gt(flag_gt),
    .blink(blink), .mem_addr(mem_addr), .mem_wr(mem_wr), .mem_wdata(mem_wdata)
  );

  qs_srt_array #(.N(N)) array_i (
    .clk(clk), .rst(rst), .in_vld(in_vld), .in_key(in_key), .mem_addr(mem_addr),
    .mem_wr(mem_wr), .mem_wdata(mem_wdata), .emit(emit), .mem_rdata(mem_rdata),
    .full(full), .busy(busy), .out_vld(out_vld), .out_key(out_key)
  );

endmodule

// File: test/qs_srt_tb_table.svh
/*
  Fixed key sets, eight keys per row with a label, index 0 first.
  Included inside the testbench module after N_KEYS is declared.
*/
`ifndef QS_SRT_TB_TABLE_SVH
`define QS_SRT_TB_TABLE_SVH

localparam int TABLE_ROWS = 8;

qs_srt_pkg::word_t table_keys [TABLE_ROWS][N_KEYS];
string             table_label [TABLE_ROWS];

// Keys arrive packed with index 0 in the top 16 bits
task automatic set_row(input int r, input string label, input logic [N_KEYS*16-1:0] keys);
  table_label[r] = label;
  for (int i = 0; i < N_KEYS; i++) begin
    table_keys[r][i] = keys[(N_KEYS - i) * 16 - 1 -: 16];
  end
endtask

task automatic load_table();
  // Already sorted, pivot A[hi] leaves 7/0 splits, deepest recursion
  set_row(0, "ascending", {16'h0001, 16'h0002, 16'h0003, 16'h0004,
                           16'h0005, 16'h0006, 16'h0007, 16'h0008});
  set_row(1, "descending", {16'h0008, 16'h0007, 16'h0006, 16'h0005,
                            16'h0004, 16'h0003, 16'h0002, 16'h0001});
  // Every compare ties, also a deep recursion
  set_row(2, "all equal", {16'h5a5a, 16'h5a5a, 16'h5a5a, 16'h5a5a,
                           16'h5a5a, 16'h5a5a, 16'h5a5a, 16'h5a5a});
  set_row(3, "duplicates", {16'h0003, 16'h0001, 16'h0003, 16'h0002,
                            16'h0001, 16'h0003, 16'h0002, 16'h0001});
  // Unsigned order puts 0x8000 and up above 0x7fff
  set_row(4, "extremes", {16'hffff, 16'h0000, 16'h8000, 16'h0000,
                          16'h7fff, 16'hffff, 16'h0001, 16'hfffe});
  set_row(5, "wide ascending", {16'h0000, 16'h0010, 16'h0100, 16'h1000,
                                16'h2000, 16'h8000, 16'hfffe, 16'hffff});
  set_row(6, "alternating", {16'h0000, 16'hffff, 16'h0000, 16'hffff,
                             16'h0000, 16'hffff, 16'h0000, 16'hffff});
  set_row(7, "mixed", {16'h1234, 16'h00ff, 16'habcd, 16'h0042,
                       16'hffff, 16'h7fff, 16'h8001, 16'h0000});
endtask

`endif

// File: test/qs_srt_tb.sv
/*
  Testbench for the quicksort engine with N = 8.
  Table rows run first, then random banks, back to back without reset.
  Two extra in_vld strobes follow every bank and must be dropped.
*/
`timescale 1ns/1ns

module qs_srt_tb;

  localparam int N_KEYS     = 8;
  localparam int RAND_ROWS  = 20;
  localparam int ROW_CYCLES = 4000;
  localparam int CLK_NS     = 20;
  localparam int JUNK_KEYS  = 2;

  logic              clk;
  logic              rst;
  logic              in_vld;
  qs_srt_pkg::word_t in_key;
  logic              out_vld;
  qs_srt_pkg::word_t out_key;
  logic              busy;

  qs_srt_pkg::word_t row_keys [N_KEYS];
  qs_srt_pkg::word_t exp_keys [N_KEYS];
  int                err_cnt;
  int                pass_rows;
  int                fail_rows;

  `include "qs_srt_tb_table.svh"

  qs_srt #(.N(N_KEYS)) qs_srt_i (
    .clk(clk), .rst(rst), .in_vld(in_vld), .in_key(in_key),
    .out_vld(out_vld), .out_key(out_key), .busy(busy)
  );

  always #(CLK_NS / 2) clk = ~clk;

  // Budget of ROW_CYCLES per row
  initial begin
    #(longint'(TABLE_ROWS + RAND_ROWS) * ROW_CYCLES * CLK_NS);
    $display("Timeout: the run did not finish within %0d cycles",
             (TABLE_ROWS + RAND_ROWS) * ROW_CYCLES);
    $display("Verification failed");
    $finish;
  end

  task automatic check_key(input qs_srt_pkg::word_t got, input qs_srt_pkg::word_t want,
                           input int idx, input string label);
    if (got !== want) begin
      $display("FAIL t=%0t row %s index %0d: out_key %h, expected %h",
               $time, label, idx, got, want);
      err_cnt++;
    end
  endtask

  task automatic check_flag(input logic got, input logic want, input string what,
                            input string label);
    if (got !== want) begin
      $display("FAIL t=%0t row %s: %s is %b, expected %b", $time, label, what, got, want);
      err_cnt++;
    end
  endtask

  // Insertion sort of the loaded keys, unsigned
  task automatic sort_reference();
    qs_srt_pkg::word_t tmp;
    int                j;
    for (int i = 0; i < N_KEYS; i++) exp_keys[i] = row_keys[i];
    for (int i = 1; i < N_KEYS; i++) begin
      tmp = exp_keys[i];
      j = i - 1;
      while (j >= 0 && exp_keys[j] > tmp) begin
        exp_keys[j + 1] = exp_keys[j];
        j--;
      end
      exp_keys[j + 1] = tmp;
    end
  endtask

  // Outputs only move on posedge, so negedge sampling is stable
  task automatic run_row(input string label);
    int errs_before;
    int wait_cnt;
    errs_before = err_cnt;
    sort_reference();
    for (int i = 0; i < N_KEYS; i++) begin
      @(negedge clk);
      check_flag(busy, 1'b0, "busy during load", label);
      in_vld = 1'b1;
      in_key = row_keys[i];
    end
    // Keys sent while busy, must not reach the bank
    for (int i = 0; i < JUNK_KEYS; i++) begin
      @(negedge clk);
      check_flag(busy, 1'b1, "busy after load", label);
      in_key = ~row_keys[i];
    end
    @(negedge clk);
    in_vld = 1'b0;
    in_key = '0;
    wait_cnt = 0;
    while (!out_vld && wait_cnt < ROW_CYCLES) begin
      check_flag(busy, 1'b1, "busy while sorting", label);
      @(negedge clk);
      wait_cnt++;
    end
    if (!out_vld) begin
      $display("Row %s: no out_vld arrived within %0d cycles of loading", label, ROW_CYCLES);
      err_cnt++;
    end else begin
      // N pulses with no gap, busy drops right after the last
      for (int k = 0; k < N_KEYS; k++) begin
        if (!out_vld) begin
          $display("Row %s: out_vld stopped after %0d keys", label, k);
          err_cnt++;
        end
        check_key(out_key, exp_keys[k], k, label);
        check_flag(busy, 1'b1, "busy while draining", label);
        @(negedge clk);
      end
      if (out_vld) begin
        $display("Row %s: more than %0d out_vld pulses", label, N_KEYS);
        err_cnt++;
      end
      check_flag(busy, 1'b0, "busy after drain", label);
    end
    if (err_cnt == errs_before) begin
      pass_rows++;
      $display("PASS row %s", label);
    end else begin
      fail_rows++;
      $display("FAIL t=%0t row %s: %0d errors", $time, label, err_cnt - errs_before);
    end
  endtask

  initial begin
    void'($urandom(38026));
    clk = 1'b0;
    rst = 1'b1;
    in_vld = 1'b0;
    in_key = '0;
    err_cnt = 0;
    pass_rows = 0;
    fail_rows = 0;
    load_table();
    repeat (8) @(negedge clk);
    rst = 1'b0;
    for (int r = 0; r < TABLE_ROWS; r++) begin
      for (int i = 0; i < N_KEYS; i++) row_keys[i] = table_keys[r][i];
      run_row(table_label[r]);
    end
    // Odd rows use a narrow range to force ties
    for (int r = 0; r < RAND_ROWS; r++) begin
      for (int i = 0; i < N_KEYS; i++) begin
        if (r % 2) row_keys[i] = qs_srt_pkg::word_t'($urandom() % 4);
        else row_keys[i] = qs_srt_pkg::word_t'($urandom());
      end
      run_row($sformatf("random %0d", r));
    end
    $display("Rows %0d, passed %0d, failed %0d, check errors %0d",
             pass_rows + fail_rows, pass_rows, fail_rows, err_cnt);
    if (err_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: qs_srt.f
+incdir+test
source/qs_srt_pkg.sv
source/qs_srt_ucode_rom.sv
source/qs_srt_seq.sv
source/qs_srt_datapath.sv
source/qs_srt_array.sv
source/qs_srt.sv
test/qs_srt_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
TOP       ?= qs_srt_tb
RTL_TOP   ?= qs_srt
FILELIST  ?= qs_srt.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Verification failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: build
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
